/* sdram_ctrl.f */
source/sdram_ctrl_pkg.sv
source/wb_port_arbiter.sv
source/refresh_timer.sv
source/sdram_cmd_seq.sv
source/read_capture.sv
source/sdram_ctrl_top.sv
test/tb_clock.sv
test/sdram_ctrl_checker.sv
test/tb_sdram_ctrl.sv

/* source/read_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module read_capture
   import sdram_ctrl_pkg::*;
#(
   parameter int CAS_LATENCY = 2
) (
   input  wire              sdram_clk_0,
   input  wire              wb_rst,
   input  wire              rd_cmd_i,
   input  wire sdram_data_t dq_i,
   output logic             rd_valid_o,
   output wb_data_t         rd_data_o
);

   logic [CAS_LATENCY+1:0] pipe_q;
   sdram_data_t            dq_q;
   sdram_data_t            hi_q;

   // Read tokens, one per CMD_READ, several may be in flight
   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         pipe_q <= '0;
      end else begin
         pipe_q <= {pipe_q[CAS_LATENCY:0], rd_cmd_i};
      end
   end

   // Input register on DQ
   always_ff @(posedge sdram_clk_0) begin
      dq_q <= dq_i;
   end

   // First beat sits in dq_q CAS_LATENCY+1 cycles after the command
   always_ff @(posedge sdram_clk_0) begin
      if (pipe_q[CAS_LATENCY]) begin
         hi_q <= dq_q;
      end
   end

   assign rd_valid_o = pipe_q[CAS_LATENCY+1];
   assign rd_data_o  = {hi_q, dq_q};

endmodule

`default_nettype wire

/* source/refresh_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module refresh_timer #(
   parameter int REFRESH_INTERVAL = 780
) (
   input  wire  sdram_clk_0,
   input  wire  wb_rst,
   input  wire  ref_ack_i,
   output logic ref_req_o
);

   localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);
   localparam logic [CNT_W-1:0] RELOAD = CNT_W'(REFRESH_INTERVAL - 1);

   logic [CNT_W-1:0] cnt_q;

   // Free-running interval counter
   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         cnt_q <= RELOAD;
      end else if (cnt_q == '0) begin
         cnt_q <= RELOAD;
      end else begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // Sticky request, set out of reset for the power-up refreshes
   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         ref_req_o <= 1'b1;
      end else if (cnt_q == '0) begin
         ref_req_o <= 1'b1;
      end else if (ref_ack_i) begin
         ref_req_o <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* source/sdram_cmd_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_seq
   import sdram_ctrl_pkg::*;
#(
   parameter int CAS_LATENCY = 2,
   parameter int T_RCD       = 2,
   parameter int T_RP        = 2,
   parameter int T_RFC       = 7
) (
   input  wire           sdram_clk_0,
   input  wire           wb_rst,
   input  wire           req_i,
   input  wire           we_i,
   input  wire wb_addr_t addr_i,
   input  wire wb_data_t wdata_i,
   input  wire wb_sel_t  sel_i,
   input  wire           ref_req_i,
   output logic          accept_o,
   output logic          wr_done_o,
   output logic          rd_cmd_o,
   output logic          ref_ack_o,
   output sdram_cmd_t    cmd_o,
   output logic          cs_n_o,
   output sdram_bank_t   ba_o,
   output sdram_addr_t   a_o,
   output sdram_data_t   dq_o,
   output logic          dq_oe_o,
   output sdram_mask_t   dqm_o
);

   localparam int WAIT_W = 8;

   // A wait of N holds ST_WAIT for N+1 cycles, the next command follows one later
   localparam logic [WAIT_W-1:0] RP_WAIT  = WAIT_W'((T_RP > 1) ? T_RP - 2 : 0);
   localparam logic [WAIT_W-1:0] RFC_WAIT = WAIT_W'((T_RFC > 1) ? T_RFC - 2 : 0);
   localparam logic [WAIT_W-1:0] RCD_WAIT = WAIT_W'((T_RCD > 0) ? T_RCD - 1 : 0);
   localparam logic [WAIT_W-1:0] RD_WAIT  = WAIT_W'(CAS_LATENCY + T_RP);
   localparam logic [WAIT_W-1:0] MRD_WAIT = WAIT_W'(0);

   localparam sdram_addr_t AP_MASK   = sdram_addr_t'(1) << AUTO_PRECHARGE_BIT;
   // Burst write, CAS latency, sequential type, burst length
   localparam sdram_addr_t MODE_WORD = {3'b000, 1'b0, 2'b00, 3'(CAS_LATENCY), 1'b0,
                                        BURST_LENGTH_CODE};

   typedef enum logic [2:0] {
      ST_POWERUP,
      ST_INIT_REF,
      ST_INIT_LMR,
      ST_IDLE,
      ST_RCD,
      ST_WR2,
      ST_WR_END,
      ST_WAIT
   } seq_state_t;

   seq_state_t        state_q;
   seq_state_t        ret_q;
   logic [WAIT_W-1:0] wait_q;
   logic              init_ref_done_q;
   logic              rw_go;

   // Activate to read/write delay has run out
   assign rw_go = (state_q == ST_RCD) && (wait_q == '0);

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         state_q         <= ST_POWERUP;
         ret_q           <= ST_IDLE;
         wait_q          <= '0;
         init_ref_done_q <= 1'b0;
         cmd_o           <= CMD_NOP;
         cs_n_o          <= 1'b1;
         ba_o            <= '0;
         a_o             <= '0;
         accept_o        <= 1'b0;
         wr_done_o       <= 1'b0;
         rd_cmd_o        <= 1'b0;
         ref_ack_o       <= 1'b0;
         dq_oe_o         <= 1'b0;
         dqm_o           <= '0;
      end else begin
         // Single-cycle strobes
         cmd_o     <= CMD_NOP;
         accept_o  <= 1'b0;
         wr_done_o <= 1'b0;
         rd_cmd_o  <= 1'b0;
         ref_ack_o <= 1'b0;

         case (state_q)
            ST_POWERUP: begin
               // Precharge all banks
               cs_n_o  <= 1'b0;
               cmd_o   <= CMD_PRECHARGE;
               a_o     <= AP_MASK;
               wait_q  <= RP_WAIT;
               ret_q   <= ST_INIT_REF;
               state_q <= ST_WAIT;
            end
            ST_INIT_REF: begin
               cmd_o           <= CMD_REFRESH;
               ref_ack_o       <= 1'b1;
               init_ref_done_q <= 1'b1;
               wait_q          <= RFC_WAIT;
               ret_q           <= init_ref_done_q ? ST_INIT_LMR : ST_INIT_REF;
               state_q         <= ST_WAIT;
            end
            ST_INIT_LMR: begin
               cmd_o   <= CMD_LOAD_MODE;
               ba_o    <= '0;
               a_o     <= MODE_WORD;
               wait_q  <= MRD_WAIT;
               ret_q   <= ST_IDLE;
               state_q <= ST_WAIT;
            end
            ST_IDLE: begin
               // Refresh goes before any access
               if (ref_req_i) begin
                  cmd_o     <= CMD_REFRESH;
                  ref_ack_o <= 1'b1;
                  wait_q    <= RFC_WAIT;
                  ret_q     <= ST_IDLE;
                  state_q   <= ST_WAIT;
               end else if (req_i) begin
                  cmd_o    <= CMD_ACTIVE;
                  accept_o <= 1'b1;
                  ba_o     <= addr_i[BANK_LSB +: BANK_W];
                  a_o      <= addr_i[ROW_LSB +: ROW_W];
                  wait_q   <= RCD_WAIT;
                  state_q  <= ST_RCD;
               end
            end
            ST_RCD: begin
               if (rw_go) begin
                  // Even column, so the high half goes out first
                  a_o <= AP_MASK | sdram_addr_t'({addr_i[COL_LSB +: COL_W], 1'b0});
                  if (we_i) begin
                     cmd_o   <= CMD_WRITE;
                     dq_oe_o <= 1'b1;
                     dqm_o   <= ~sel_i[3:2];
                     state_q <= ST_WR2;
                  end else begin
                     cmd_o    <= CMD_READ;
                     rd_cmd_o <= 1'b1;
                     wait_q   <= RD_WAIT;
                     ret_q    <= ST_IDLE;
                     state_q  <= ST_WAIT;
                  end
               end else begin
                  wait_q <= wait_q - 1'b1;
               end
            end
            ST_WR2: begin
               dqm_o   <= ~sel_i[1:0];
               state_q <= ST_WR_END;
            end
            ST_WR_END: begin
               dq_oe_o   <= 1'b0;
               dqm_o     <= '0;
               wr_done_o <= 1'b1;
               wait_q    <= RP_WAIT;
               ret_q     <= ST_IDLE;
               state_q   <= ST_WAIT;
            end
            ST_WAIT: begin
               if (wait_q == '0) begin
                  state_q <= ret_q;
               end else begin
                  wait_q <= wait_q - 1'b1;
               end
            end
            default: begin
               state_q <= ST_POWERUP;
            end
         endcase
      end
   end

   // Write beats, high half with the command, low half next cycle
   always_ff @(posedge sdram_clk_0) begin
      if (rw_go && we_i) begin
         dq_o <= wdata_i[31:16];
      end else if (state_q == ST_WR2) begin
         dq_o <= wdata_i[15:0];
      end
   end

endmodule

`default_nettype wire

/* source/sdram_ctrl_pkg.sv */
`default_nettype none

package sdram_ctrl_pkg;

   // Wishbone side
   typedef logic [31:0] wb_data_t;
   typedef logic [3:0]  wb_sel_t;
   typedef logic [22:0] wb_addr_t;

   // SDRAM side, one 16-bit part
   typedef logic [15:0] sdram_data_t;
   typedef logic [1:0]  sdram_mask_t;
   typedef logic [1:0]  sdram_bank_t;
   typedef logic [12:0] sdram_addr_t;

   // Command pins as {ras_n, cas_n, we_n}
   typedef enum logic [2:0] {
      CMD_LOAD_MODE = 3'b000,
      CMD_REFRESH   = 3'b001,
      CMD_PRECHARGE = 3'b010,
      CMD_ACTIVE    = 3'b011,
      CMD_WRITE     = 3'b100,
      CMD_READ      = 3'b101,
      CMD_NOP       = 3'b111
   } sdram_cmd_t;

   // Word address split, bank on top, column word at the bottom
   localparam int COL_LSB  = 0;
   localparam int COL_W    = 8;
   localparam int ROW_LSB  = 8;
   localparam int ROW_W    = 13;
   localparam int BANK_LSB = 21;
   localparam int BANK_W   = 2;

   // A10 selects auto-precharge on read/write, all banks on precharge
   localparam int AUTO_PRECHARGE_BIT = 10;

   // Mode register burst field, two beats per access
   localparam logic [2:0] BURST_LENGTH_CODE = 3'b001;

endpackage

`default_nettype wire

/* source/sdram_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top
   import sdram_ctrl_pkg::*;
#(
   parameter int CAS_LATENCY      = 2,
   parameter int T_RCD            = 2,
   parameter int T_RP             = 2,
   parameter int T_RFC            = 7,
   parameter int REFRESH_INTERVAL = 780
) (
   input  wire           sdram_clk_0,
   input  wire           wb_rst,
   // Port 0
   input  wire           wb0_cyc_i,
   input  wire           wb0_stb_i,
   input  wire           wb0_we_i,
   input  wire wb_addr_t wb0_adr_i,
   input  wire wb_sel_t  wb0_sel_i,
   input  wire wb_data_t wb0_dat_i,
   output wb_data_t      wb0_dat_o,
   output logic          wb0_ack_o,
   // Port 1
   input  wire           wb1_cyc_i,
   input  wire           wb1_stb_i,
   input  wire           wb1_we_i,
   input  wire wb_addr_t wb1_adr_i,
   input  wire wb_sel_t  wb1_sel_i,
   input  wire wb_data_t wb1_dat_i,
   output wb_data_t      wb1_dat_o,
   output logic          wb1_ack_o,
   // SDRAM pads
   output sdram_bank_t   ba_o,
   output sdram_addr_t   a_o,
   output logic          cs_n_o,
   output logic          ras_n_o,
   output logic          cas_n_o,
   output logic          we_n_o,
   output sdram_data_t   dq_o,
   output logic          dq_oe_o,
   output sdram_mask_t   dqm_o,
   input  wire sdram_data_t dq_i
);

   logic       req, we, accept, wr_done, rd_cmd, rd_valid;
   logic       ref_req, ref_ack;
   wb_addr_t   addr;
   wb_data_t   wdata, rd_data;
   wb_sel_t    sel;
   sdram_cmd_t cmd;

   assign {ras_n_o, cas_n_o, we_n_o} = cmd;

   wb_port_arbiter u_arbiter (
      .sdram_clk_0(sdram_clk_0), .wb_rst(wb_rst),
      .wb0_cyc_i(wb0_cyc_i), .wb0_stb_i(wb0_stb_i), .wb0_we_i(wb0_we_i),
      .wb0_adr_i(wb0_adr_i), .wb0_sel_i(wb0_sel_i), .wb0_dat_i(wb0_dat_i),
      .wb0_dat_o(wb0_dat_o), .wb0_ack_o(wb0_ack_o),
      .wb1_cyc_i(wb1_cyc_i), .wb1_stb_i(wb1_stb_i), .wb1_we_i(wb1_we_i),
      .wb1_adr_i(wb1_adr_i), .wb1_sel_i(wb1_sel_i), .wb1_dat_i(wb1_dat_i),
      .wb1_dat_o(wb1_dat_o), .wb1_ack_o(wb1_ack_o),
      .accept_i(accept), .wr_done_i(wr_done), .rd_valid_i(rd_valid), .rd_data_i(rd_data),
      .req_o(req), .we_o(we), .addr_o(addr), .wdata_o(wdata), .sel_o(sel)
   );

   refresh_timer #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) u_refresh (
      .sdram_clk_0(sdram_clk_0), .wb_rst(wb_rst),
      .ref_ack_i(ref_ack), .ref_req_o(ref_req)
   );

   sdram_cmd_seq #(
      .CAS_LATENCY(CAS_LATENCY), .T_RCD(T_RCD), .T_RP(T_RP), .T_RFC(T_RFC)
   ) u_cmd_seq (
      .sdram_clk_0(sdram_clk_0), .wb_rst(wb_rst),
      .req_i(req), .we_i(we), .addr_i(addr), .wdata_i(wdata), .sel_i(sel),
      .ref_req_i(ref_req),
      .accept_o(accept), .wr_done_o(wr_done), .rd_cmd_o(rd_cmd), .ref_ack_o(ref_ack),
      .cmd_o(cmd), .cs_n_o(cs_n_o), .ba_o(ba_o), .a_o(a_o),
      .dq_o(dq_o), .dq_oe_o(dq_oe_o), .dqm_o(dqm_o)
   );

   read_capture #(.CAS_LATENCY(CAS_LATENCY)) u_read_capture (
      .sdram_clk_0(sdram_clk_0), .wb_rst(wb_rst),
      .rd_cmd_i(rd_cmd), .dq_i(dq_i),
      .rd_valid_o(rd_valid), .rd_data_o(rd_data)
   );

endmodule

`default_nettype wire

/* source/wb_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_port_arbiter
   import sdram_ctrl_pkg::*;
(
   input  wire           sdram_clk_0,
   input  wire           wb_rst,
   // Port 0
   input  wire           wb0_cyc_i,
   input  wire           wb0_stb_i,
   input  wire           wb0_we_i,
   input  wire wb_addr_t wb0_adr_i,
   input  wire wb_sel_t  wb0_sel_i,
   input  wire wb_data_t wb0_dat_i,
   output wb_data_t      wb0_dat_o,
   output logic          wb0_ack_o,
   // Port 1
   input  wire           wb1_cyc_i,
   input  wire           wb1_stb_i,
   input  wire           wb1_we_i,
   input  wire wb_addr_t wb1_adr_i,
   input  wire wb_sel_t  wb1_sel_i,
   input  wire wb_data_t wb1_dat_i,
   output wb_data_t      wb1_dat_o,
   output logic          wb1_ack_o,
   // Sequencer side
   input  wire           accept_i,
   input  wire           wr_done_i,
   input  wire           rd_valid_i,
   input  wire wb_data_t rd_data_i,
   output logic          req_o,
   output logic          we_o,
   output wb_addr_t      addr_o,
   output wb_data_t      wdata_o,
   output wb_sel_t       sel_o
);

   logic busy_q;
   logic owner_q;
   logic pend0, pend1;
   logic done;

   // A port has a pending request for as long as its master holds cyc and stb
   assign pend0 = wb0_cyc_i & wb0_stb_i;
   assign pend1 = wb1_cyc_i & wb1_stb_i;

   // Completion that matches the direction of the latched request
   assign done = busy_q & (we_o ? wr_done_i : rd_valid_i);

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         busy_q  <= 1'b0;
         owner_q <= 1'b0;
         req_o   <= 1'b0;
      end else if (!busy_q) begin
         // Port 0 wins a tie
         if (pend0 | pend1) begin
            busy_q  <= 1'b1;
            req_o   <= 1'b1;
            owner_q <= ~pend0;
         end
      end else begin
         if (accept_i) begin
            req_o <= 1'b0;
         end
         if (done) begin
            busy_q <= 1'b0;
         end
      end
   end

   // Request fields, frozen while busy
   always_ff @(posedge sdram_clk_0) begin
      if (!busy_q) begin
         if (pend0) begin
            we_o    <= wb0_we_i;
            addr_o  <= wb0_adr_i;
            wdata_o <= wb0_dat_i;
            sel_o   <= wb0_sel_i;
         end else begin
            we_o    <= wb1_we_i;
            addr_o  <= wb1_adr_i;
            wdata_o <= wb1_dat_i;
            sel_o   <= wb1_sel_i;
         end
      end
   end

   // Single-cycle ack to the owner, read data valid in the same cycle
   assign wb0_ack_o = done & ~owner_q;
   assign wb1_ack_o = done & owner_q;
   assign wb0_dat_o = rd_data_i;
   assign wb1_dat_o = rd_data_i;

endmodule

`default_nettype wire

/* test/sdram_ctrl_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_checker
   import sdram_ctrl_pkg::*;
#(
   parameter int T_RCD = 2
) (
   input wire              clk_i,
   input wire              rst_i,
   input wire              wb0_cyc_i,
   input wire              wb0_stb_i,
   input wire              wb0_ack_i,
   input wire              wb1_cyc_i,
   input wire              wb1_stb_i,
   input wire              wb1_ack_i,
   input wire [2:0]        cmd_i,
   input wire sdram_addr_t a_i,
   input wire              dq_oe_i
);

   logic [7:0]  since_act_q;
   logic        rw_cmd;
   // Failed assertion count
   int unsigned fail_count = 0;

   assign rw_cmd = (cmd_i == CMD_READ) || (cmd_i == CMD_WRITE);

   // Edges since the last activate, saturating
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         since_act_q <= '0;
      end else if (cmd_i == CMD_ACTIVE) begin
         since_act_q <= 8'd1;
      end else if (since_act_q != 8'hff) begin
         since_act_q <= since_act_q + 8'd1;
      end
   end

   ack0_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      wb0_ack_i |-> (wb0_cyc_i && wb0_stb_i)) else begin
         fail_count++;
         $error("port 0 ack outside cyc/stb");
      end
   ack1_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
      wb1_ack_i |-> (wb1_cyc_i && wb1_stb_i)) else begin
         fail_count++;
         $error("port 1 ack outside cyc/stb");
      end
   ack0_single: assert property (@(posedge clk_i) disable iff (rst_i)
      wb0_ack_i |=> !wb0_ack_i) else begin
         fail_count++;
         $error("port 0 ack longer than one cycle");
      end
   ack1_single: assert property (@(posedge clk_i) disable iff (rst_i)
      wb1_ack_i |=> !wb1_ack_i) else begin
         fail_count++;
         $error("port 1 ack longer than one cycle");
      end

   // Column command after tRCD, always with auto-precharge
   rcd_and_ap: assert property (@(posedge clk_i) disable iff (rst_i)
      rw_cmd |-> (since_act_q >= T_RCD) && a_i[AUTO_PRECHARGE_BIT]) else begin
         fail_count++;
         $error("read/write too early or without auto-precharge");
      end

   // Output enable spans the write command cycle and the one after
   oe_window: assert property (@(posedge clk_i) disable iff (rst_i)
      dq_oe_i == ((cmd_i == CMD_WRITE) || ($past(cmd_i) == CMD_WRITE))) else begin
         fail_count++;
         $error("dq_oe_o outside the write beats");
      end

endmodule

bind sdram_ctrl_top sdram_ctrl_checker #(.T_RCD(T_RCD)) u_checker (
   .clk_i(sdram_clk_0), .rst_i(wb_rst),
   .wb0_cyc_i(wb0_cyc_i), .wb0_stb_i(wb0_stb_i), .wb0_ack_i(wb0_ack_o),
   .wb1_cyc_i(wb1_cyc_i), .wb1_stb_i(wb1_stb_i), .wb1_ack_i(wb1_ack_o),
   .cmd_i({ras_n_o, cas_n_o, we_n_o}), .a_i(a_o), .dq_oe_i(dq_oe_o)
);

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk_o,
   output logic rst_o
);

   // 10 ns period
   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // Reset held for three rising edges
   initial begin
      rst_o = 1'b1;
      repeat (3) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

`default_nettype wire

/* test/tb_sdram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl
   import sdram_ctrl_pkg::*;
;

   localparam int CL          = 2;
   localparam int T_RCD       = 2;
   localparam int T_RP        = 2;
   localparam int T_RFC       = 7;
   localparam int REF_INT     = 100;
   localparam int N_ADDR      = 8;
   localparam int N_TRANS     = 16 + N_ADDR + 4;
   localparam int REF_MAX     = REF_INT + T_RCD + CL + T_RP + 8;
   localparam int POWERUP_CYC = T_RP + 2 * T_RFC + 8;
   localparam int TAIL_CYC    = 3 * REF_INT;
   localparam longint WATCHDOG_NS =
      (longint'(N_TRANS) * (REF_INT + 40) + POWERUP_CYC + TAIL_CYC) * 10;

   wire sdram_clk_0;
   wire wb_rst;

   logic        wb0_cyc_i, wb0_stb_i, wb0_we_i, wb1_cyc_i, wb1_stb_i, wb1_we_i;
   wb_addr_t    wb0_adr_i, wb1_adr_i;
   wb_sel_t     wb0_sel_i, wb1_sel_i;
   wb_data_t    wb0_dat_i, wb1_dat_i, wb0_dat_o, wb1_dat_o;
   logic        wb0_ack_o, wb1_ack_o;
   sdram_bank_t ba_o;
   sdram_addr_t a_o;
   logic        cs_n_o, ras_n_o, cas_n_o, we_n_o, dq_oe_o;
   sdram_data_t dq_o, dq_i;
   sdram_mask_t dqm_o;
   logic [2:0]  cmd;

   int unsigned tick;
   int          error_count;
   integer      seed;

   // SDRAM model state
   sdram_data_t mem [int];
   sdram_addr_t open_row [4];
   sdram_data_t rd_sched [16];
   logic        wr2_pend;
   int          wr2_key;

   // Shadow of what each Wishbone word should hold
   wb_data_t    shadow [int];

   // Power-up and refresh monitor state
   int          init_idx;
   logic        init_done;
   int unsigned last_ref;
   logic        ref_seen;

   tb_clock u_clock (.clk_o(sdram_clk_0), .rst_o(wb_rst));

   sdram_ctrl_top #(
      .CAS_LATENCY(CL), .T_RCD(T_RCD), .T_RP(T_RP), .T_RFC(T_RFC),
      .REFRESH_INTERVAL(REF_INT)
   ) DUT (
      .sdram_clk_0(sdram_clk_0), .wb_rst(wb_rst),
      .wb0_cyc_i(wb0_cyc_i), .wb0_stb_i(wb0_stb_i), .wb0_we_i(wb0_we_i),
      .wb0_adr_i(wb0_adr_i), .wb0_sel_i(wb0_sel_i), .wb0_dat_i(wb0_dat_i),
      .wb0_dat_o(wb0_dat_o), .wb0_ack_o(wb0_ack_o),
      .wb1_cyc_i(wb1_cyc_i), .wb1_stb_i(wb1_stb_i), .wb1_we_i(wb1_we_i),
      .wb1_adr_i(wb1_adr_i), .wb1_sel_i(wb1_sel_i), .wb1_dat_i(wb1_dat_i),
      .wb1_dat_o(wb1_dat_o), .wb1_ack_o(wb1_ack_o),
      .ba_o(ba_o), .a_o(a_o), .cs_n_o(cs_n_o), .ras_n_o(ras_n_o), .cas_n_o(cas_n_o),
      .we_n_o(we_n_o), .dq_o(dq_o), .dq_oe_o(dq_oe_o), .dqm_o(dqm_o), .dq_i(dq_i)
   );

   assign cmd = {ras_n_o, cas_n_o, we_n_o};

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      error_count++;
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, got);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic report_problem(input string text);
      error_count++;
      $display("Error at %0t: %s", $time, text);
      $display("Checks failed");
      $fatal(1);
   endtask

   function automatic int beat_key(input sdram_bank_t b, input sdram_addr_t r,
                                   input logic [9:0] c);
      return int'({b, r, c});
   endfunction

   function automatic sdram_data_t beat_get(input int key);
      return mem.exists(key) ? mem[key] : '0;
   endfunction

   // Byte lanes are written only where DQM is low
   function automatic sdram_data_t beat_merge(input sdram_data_t old, input sdram_data_t nw,
                                              input sdram_mask_t m);
      return {m[1] ? old[15:8] : nw[15:8], m[0] ? old[7:0] : nw[7:0]};
   endfunction

   function automatic wb_data_t shadow_merge(input wb_data_t old, input wb_data_t nw,
                                             input wb_sel_t s);
      wb_data_t r;
      for (int i = 0; i < 4; i++) begin
         r[i*8 +: 8] = s[i] ? nw[i*8 +: 8] : old[i*8 +: 8];
      end
      return r;
   endfunction

   always @(posedge sdram_clk_0) begin
      tick <= tick + 1;
   end

   // Behavioral SDRAM, commands sampled on the rising edge
   always @(posedge sdram_clk_0) begin
      int          k;
      logic        do_wr2;
      do_wr2 = wr2_pend;
      wr2_pend = 1'b0;
      dq_i <= rd_sched[tick % 16];
      rd_sched[tick % 16] = '0;
      if (do_wr2) begin
         mem[wr2_key] = beat_merge(beat_get(wr2_key), dq_o, dqm_o);
      end
      if (!wb_rst && !cs_n_o) begin
         case (cmd)
            CMD_ACTIVE: open_row[ba_o] = a_o;
            CMD_READ: begin
               k = beat_key(ba_o, open_row[ba_o], a_o[9:0]);
               rd_sched[(tick + CL - 1) % 16] = beat_get(k);
               rd_sched[(tick + CL) % 16] = beat_get(k + 1);
            end
            CMD_WRITE: begin
               k = beat_key(ba_o, open_row[ba_o], a_o[9:0]);
               mem[k] = beat_merge(beat_get(k), dq_o, dqm_o);
               wr2_pend = 1'b1;
               wr2_key = k + 1;
            end
            default: ;
         endcase
      end
   end

   // Power-up order, refresh spacing and tRFC
   always @(posedge sdram_clk_0) begin
      if (!wb_rst) begin
         if (!init_done) begin
            assert (!wb0_ack_o && !wb1_ack_o)
               else report_problem("ack seen before the load-mode command");
         end
         if (!cs_n_o && cmd != CMD_NOP) begin
            if (ref_seen) begin
               assert (tick - last_ref >= T_RFC)
                  else report_mismatch("cmd gap after refresh", T_RFC, tick - last_ref);
            end
            if (init_idx < 4) begin
               case (init_idx)
                  0: assert (cmd == CMD_PRECHARGE && a_o[AUTO_PRECHARGE_BIT])
                        else report_mismatch("power-up cmd 0", CMD_PRECHARGE, cmd);
                  1, 2: assert (cmd == CMD_REFRESH)
                        else report_mismatch("power-up refresh cmd", CMD_REFRESH, cmd);
                  default: begin
                     assert (cmd == CMD_LOAD_MODE)
                        else report_mismatch("power-up cmd 3", CMD_LOAD_MODE, cmd);
                     assert (a_o[6:4] == CL && a_o[2:0] == BURST_LENGTH_CODE)
                        else report_mismatch("mode word",
                                             {3'(CL), 1'b0, BURST_LENGTH_CODE}, a_o[6:0]);
                     init_done <= 1'b1;
                  end
               endcase
               init_idx <= init_idx + 1;
            end
            if (cmd == CMD_REFRESH) begin
               if (ref_seen) begin
                  assert (tick - last_ref <= REF_MAX)
                     else report_mismatch("refresh spacing", REF_MAX, tick - last_ref);
               end
               ref_seen <= 1'b1;
               last_ref <= tick;
            end
         end
      end
   end

   // Protocol checker status
   always @(negedge sdram_clk_0) begin
      if (DUT.u_checker.fail_count != 0) begin
         report_problem("a protocol assertion in the bound checker failed");
      end
   end

   // One Wishbone classic transfer on the given port
   task automatic wb_access(input int port, input logic we, input wb_addr_t adr,
                            input wb_sel_t sel, input wb_data_t wdat,
                            output wb_data_t rdat, output int unsigned ack_tick);
      logic got;
      got = 1'b0;
      @(posedge sdram_clk_0);
      if (port == 0) begin
         wb0_cyc_i <= 1'b1;
         wb0_stb_i <= 1'b1;
         wb0_we_i  <= we;
         wb0_adr_i <= adr;
         wb0_sel_i <= sel;
         wb0_dat_i <= wdat;
      end else begin
         wb1_cyc_i <= 1'b1;
         wb1_stb_i <= 1'b1;
         wb1_we_i  <= we;
         wb1_adr_i <= adr;
         wb1_sel_i <= sel;
         wb1_dat_i <= wdat;
      end
      while (!got) begin
         @(posedge sdram_clk_0);
         if ((port == 0) ? wb0_ack_o : wb1_ack_o) begin
            got = 1'b1;
            rdat = (port == 0) ? wb0_dat_o : wb1_dat_o;
            ack_tick = tick;
            if (port == 0) begin
               wb0_cyc_i <= 1'b0;
               wb0_stb_i <= 1'b0;
            end else begin
               wb1_cyc_i <= 1'b0;
               wb1_stb_i <= 1'b0;
            end
         end
      end
   endtask

   task automatic write_word(input int port, input wb_addr_t adr, input wb_sel_t sel,
                             input wb_data_t dat, output int unsigned t);
      wb_data_t unused;
      wb_access(port, 1'b1, adr, sel, dat, unused, t);
      shadow[adr] = shadow_merge(shadow.exists(adr) ? shadow[adr] : '0, dat, sel);
   endtask

   task automatic read_and_compare(input int port, input wb_addr_t adr);
      wb_data_t    got;
      wb_data_t    exp;
      int unsigned t;
      wb_access(port, 1'b0, adr, 4'hf, '0, got, t);
      exp = shadow.exists(adr) ? shadow[adr] : '0;
      assert (got === exp)
         else report_mismatch(port == 0 ? "wb0_dat_o" : "wb1_dat_o", exp, got);
   endtask

   // Watchdog sized from the transaction count
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: no ack arrived in time");
      $display("Checks failed");
      $fatal(1);
   end

   initial begin
      wb_addr_t    addrs [N_ADDR];
      int unsigned t0, t1;
      seed = 32'h5bf330bf;
      error_count = 0;
      tick = 0;
      init_idx = 0;
      init_done = 1'b0;
      ref_seen = 1'b0;
      last_ref = 0;
      wr2_pend = 1'b0;
      wr2_key = 0;
      dq_i = '0;
      for (int i = 0; i < 16; i++) begin
         rd_sched[i] = '0;
      end
      for (int i = 0; i < 4; i++) begin
         open_row[i] = '0;
      end
      {wb0_cyc_i, wb0_stb_i, wb0_we_i, wb1_cyc_i, wb1_stb_i, wb1_we_i} = '0;
      {wb0_adr_i, wb0_sel_i, wb0_dat_i} = '0;
      {wb1_adr_i, wb1_sel_i, wb1_dat_i} = '0;

      @(negedge wb_rst);
      for (int i = 0; i < N_ADDR; i++) begin
         addrs[i] = wb_addr_t'($random(seed));
      end
      // Repeated addresses exercise byte merging
      for (int i = 0; i < 16; i++) begin
         write_word(i % 2, addrs[$unsigned($random(seed)) % N_ADDR],
                    wb_sel_t'($random(seed)), wb_data_t'($random(seed)), t0);
      end
      for (int i = 0; i < N_ADDR; i++) begin
         read_and_compare((i + 1) % 2, addrs[i]);
      end

      // Both ports request in the same cycle
      fork
         write_word(0, 23'h000155, 4'hf, wb_data_t'($random(seed)), t0);
         write_word(1, 23'h0002aa, 4'hf, wb_data_t'($random(seed)), t1);
      join
      assert (t0 < t1) else report_mismatch("port 0 ack tick", t1, t0);
      read_and_compare(1, 23'h000155);
      read_and_compare(0, 23'h0002aa);

      // Let a few more refreshes go by
      repeat (TAIL_CYC) @(posedge sdram_clk_0);
      if (error_count == 0 && DUT.u_checker.fail_count == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("Checks failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire
